// ==== source/vector_pkg.sv ====
// vector core package: widths, instruction fields, codes, records, byte select and merge
`default_nettype none

package vector_pkg;

	localparam int data_width     = 64;
	localparam int byte_count     = data_width / 8;
	localparam int reg_count      = 32;
	localparam int reg_addr_width = 5;
	localparam int shamt_width    = 5;

	// instruction fields, bit 0 is the msb
	localparam int opcode_pos   = 0;
	localparam int opcode_width = 6;
	localparam int rd_pos       = 6;
	localparam int ra_pos       = 11;
	localparam int rb_pos       = 16; // also the immediate shift amount
	localparam int ppp_pos      = 21;
	localparam int ww_pos       = 24;
	localparam int fn_pos       = 26;
	localparam int fn_width     = 6;

	localparam logic [opcode_width-1:0] opcode_alu = 6'b101010;

	// function field plus one, 8 and 9 were the multiplies
	typedef enum logic [4:0] {
		op_nop  = 5'd0,
		op_and  = 5'd1,
		op_or   = 5'd2,
		op_xor  = 5'd3,
		op_not  = 5'd4,
		op_mov  = 5'd5,
		op_add  = 5'd6,
		op_sub  = 5'd7,
		op_rtth = 5'd10,
		op_sll  = 5'd11,
		op_slli = 5'd12,
		op_srl  = 5'd13,
		op_srli = 5'd14,
		op_sra  = 5'd15,
		op_srai = 5'd16
	} alu_op_e;

	typedef enum logic [1:0] {ww_byte, ww_half, ww_word, ww_double} ww_e;

	// codes 5 to 7 write no bytes
	typedef enum logic [2:0] {ppp_all, ppp_upper, ppp_lower, ppp_even, ppp_odd} ppp_e;

	typedef logic [0:data_width-1] vec_t; // byte 0 is the most significant
	typedef logic [reg_addr_width-1:0] reg_idx_t;

	typedef struct packed {
		alu_op_e                op;
		ww_e                    ww;
		ppp_e                   ppp;
		logic [shamt_width-1:0] shamt;
		reg_idx_t               ra;
		reg_idx_t               rb;
		reg_idx_t               rd;
		logic                   wr;
		vec_t                   a;
		vec_t                   b;
	} exec_rec_t;

	typedef struct packed {
		logic     wr;
		reg_idx_t rd;
		ppp_e     ppp;
		vec_t     data;
	} wb_rec_t;

	function automatic logic [0:byte_count-1] byte_enables(input ppp_e ppp);
		case (ppp)
			ppp_all:   return 8'b1111_1111;
			ppp_upper: return 8'b1111_0000;
			ppp_lower: return 8'b0000_1111;
			ppp_even:  return 8'b1010_1010;
			ppp_odd:   return 8'b0101_0101;
			default:   return '0;
		endcase
	endfunction

	function automatic vec_t ppp_merge(input vec_t new_word, input vec_t old_word,
		input ppp_e ppp);
		logic [0:byte_count-1] en;
		vec_t merged;
		en = byte_enables(ppp);
		for (int i = 0; i < byte_count; i++)
		begin
			merged[8*i +: 8] = en[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
		end
		return merged;
	endfunction

endpackage

`default_nettype wire

// ==== source/vector_regfile.sv ====
// 32 x 64-bit vector register file with byte-select write
`timescale 1ns/1ps
`default_nettype none

module vector_regfile import vector_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  reg_idx_t ra,
	input  reg_idx_t rb,
	input  wb_rec_t  wb,
	output vec_t     rdata_a,
	output vec_t     rdata_b
);

	vec_t regs [reg_count];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < reg_count; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wb.wr && wb.rd != '0) // register 0 stays zero
		begin
			regs[wb.rd] <= ppp_merge(wb.data, regs[wb.rd], wb.ppp);
		end
	end

	// combinational reads, decode forwards the pending write
	assign rdata_a = regs[ra];
	assign rdata_b = regs[rb];

endmodule

`default_nettype wire

// ==== source/vector_alu.sv ====
// lane-parallel vector ALU, lanes of 8, 16, 32 or 64 bits
`timescale 1ns/1ps
`default_nettype none

module vector_alu import vector_pkg::*; (
	input  alu_op_e                op,
	input  ww_e                    ww,
	input  vec_t                   a,
	input  vec_t                   b,
	input  logic [shamt_width-1:0] shamt,
	output vec_t                   result
);

	// one full-word result per lane width, picked by ww
	wire [0:data_width-1] lane_res [4];

	for (genvar w = 0; w < 4; w++)
	begin : g_width
		localparam int lw = 8 << w;
		localparam int sw = 3 + w; // log2 of the lane width
		localparam int iw = (sw > shamt_width) ? shamt_width : sw;

		for (genvar l = 0; l < data_width / lw; l++)
		begin : g_lane
			logic [lw-1:0] x;
			logic [lw-1:0] y;
			logic [lw-1:0] r;
			logic [sw-1:0] rsh;
			logic [iw-1:0] ish;

			assign x   = a[l*lw +: lw];
			assign y   = b[l*lw +: lw];
			assign rsh = y[sw-1:0];      // amount from the same lane of b
			assign ish = shamt[iw-1:0];

			always_comb
			begin
				case (op)
					op_add:  r = x + y;  // wraps inside the lane
					op_sub:  r = x - y;
					op_rtth: r = {x[lw/2-1:0], x[lw-1:lw/2]};
					op_sll:  r = x << rsh;
					op_slli: r = x << ish;
					op_srl:  r = x >> rsh;
					op_srli: r = x >> ish;
					op_sra:  r = $signed(x) >>> rsh;
					op_srai: r = $signed(x) >>> ish;
					default: r = '0;
				endcase
			end

			assign lane_res[w][l*lw +: lw] = r;
		end
	end

	always_comb
	begin
		case (op)
			op_and:  result = a & b;
			op_or:   result = a | b;
			op_xor:  result = a ^ b;
			op_not:  result = ~a;
			op_mov:  result = a;
			op_add,
			op_sub,
			op_rtth,
			op_sll,
			op_slli,
			op_srl,
			op_srli,
			op_sra,
			op_srai: result = lane_res[ww];
			default: result = '0; // nop and the old multiply codes
		endcase
	end

endmodule

`default_nettype wire

// ==== source/vector_decode.sv ====
// decode stage: instruction register, field decode, write-back forwarding, execute record
`timescale 1ns/1ps
`default_nettype none

module vector_decode import vector_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [0:31] instruction,
	input  vec_t        rdata_a,
	input  vec_t        rdata_b,
	input  wb_rec_t     wb,
	output reg_idx_t    ra,
	output reg_idx_t    rb,
	output exec_rec_t   exec
);

	logic [0:31] ir;
	logic [opcode_width-1:0] opcode;
	logic [fn_width-1:0] funct;
	logic [fn_width:0] op_sum;
	logic is_alu;
	logic imm_shift;
	alu_op_e op;
	reg_idx_t rd;
	vec_t a_val;
	vec_t b_val;
	exec_rec_t next_rec;

	always_ff @(posedge clk)
	begin
		if (reset)
			ir <= '0;
		else
			ir <= instruction;
	end

	assign opcode = ir[opcode_pos +: opcode_width];
	assign funct  = ir[fn_pos +: fn_width];
	assign is_alu = (opcode == opcode_alu);
	assign op_sum = funct + 1'b1;

	// function codes past srai decode as nop
	assign op = (is_alu && op_sum <= (fn_width+1)'(op_srai)) ? alu_op_e'(op_sum[4:0]) : op_nop;

	assign imm_shift = (op == op_slli) || (op == op_srli) || (op == op_srai);

	// non-alu words read and write nothing
	assign ra = is_alu ? ir[ra_pos +: reg_addr_width] : '0;
	assign rb = (is_alu && !imm_shift) ? ir[rb_pos +: reg_addr_width] : '0;
	assign rd = is_alu ? ir[rd_pos +: reg_addr_width] : '0;

	// result still in write-back, not yet in the register file
	assign a_val = (wb.wr && wb.rd == ra) ? ppp_merge(wb.data, rdata_a, wb.ppp) : rdata_a;
	assign b_val = (wb.wr && wb.rd == rb) ? ppp_merge(wb.data, rdata_b, wb.ppp) : rdata_b;

	always_comb
	begin
		next_rec.op    = op;
		next_rec.ww    = ww_e'(ir[ww_pos +: 2]);
		next_rec.ppp   = ppp_e'(ir[ppp_pos +: 3]);
		next_rec.shamt = ir[rb_pos +: shamt_width];
		next_rec.ra    = ra;
		next_rec.rb    = rb;
		next_rec.rd    = rd;
		next_rec.wr    = is_alu && (rd != '0); // rd 0 never written
		next_rec.a     = a_val;
		next_rec.b     = b_val;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			exec <= '0;
		else
			exec <= next_rec;
	end

endmodule

`default_nettype wire

// ==== source/vector_execute.sv ====
// execute stage: write-back forwarding, ALU and write-back record register
`timescale 1ns/1ps
`default_nettype none

module vector_execute import vector_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  exec_rec_t exec,
	output wb_rec_t   wb
);

	vec_t a_fwd;
	vec_t b_fwd;
	vec_t result;

	// previous instruction's result, merged over the operand it replaces
	assign a_fwd = (wb.wr && wb.rd == exec.ra) ? ppp_merge(wb.data, exec.a, wb.ppp) : exec.a;
	assign b_fwd = (wb.wr && wb.rd == exec.rb) ? ppp_merge(wb.data, exec.b, wb.ppp) : exec.b;

	vector_alu alu_i (
		.op     (exec.op),
		.ww     (exec.ww),
		.a      (a_fwd),
		.b      (b_fwd),
		.shamt  (exec.shamt),
		.result (result)
	);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wb <= '0;
		end
		else
		begin
			wb.wr   <= exec.wr;
			wb.rd   <= exec.rd;
			wb.ppp  <= exec.ppp;
			wb.data <= result;
		end
	end

endmodule

`default_nettype wire

// ==== source/vector_core.sv ====
// vector core top: decode, register file and execute stage
`timescale 1ns/1ps
`default_nettype none

module vector_core import vector_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [0:31] instruction,
	output wb_rec_t     wb
);

	reg_idx_t  ra;
	reg_idx_t  rb;
	vec_t      rdata_a;
	vec_t      rdata_b;
	exec_rec_t exec;

	vector_decode decode_i (
		.clk         (clk),
		.reset       (reset),
		.instruction (instruction),
		.rdata_a     (rdata_a),
		.rdata_b     (rdata_b),
		.wb          (wb),
		.ra          (ra),
		.rb          (rb),
		.exec        (exec)
	);

	vector_regfile regfile_i (
		.clk     (clk),
		.reset   (reset),
		.ra      (ra),
		.rb      (rb),
		.wb      (wb),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	vector_execute execute_i (
		.clk   (clk),
		.reset (reset),
		.exec  (exec),
		.wb    (wb)
	);

endmodule

`default_nettype wire

// ==== test/vector_core_properties.sv ====
// write-back port assertions for the vector core, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module vector_core_properties import vector_pkg::*; (
	input logic    clk,
	input logic    reset,
	input wb_rec_t wb
);

	int failures = 0; // assertion failures seen so far

	wb_low_after_reset: assert property (@(posedge clk) reset |=> !wb.wr)
	else
	begin
		failures++;
		$error("write flag set in the cycle after reset");
	end

	// rd 0 never reaches the write port
	wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset) wb.wr |-> wb.rd != '0)
	else
	begin
		failures++;
		$error("write flag set with rd 0");
	end

	wb_known: assert property (@(posedge clk) disable iff (reset) wb.wr |-> !$isunknown(wb))
	else
	begin
		failures++;
		$error("written wb record has unknown bits");
	end

endmodule

bind vector_core vector_core_properties props_i (.*);

`default_nettype wire

// ==== test/vector_core_tb.sv ====
// vector core testbench: clock, reset, directed and random streams, reference model, compare
`timescale 1ns/1ps
`default_nettype none

module vector_core_tb import vector_pkg::*; ();

	localparam int reset_cycles   = 5;
	localparam int random_count   = 400;
	localparam int directed_bound = 70; // directed words, drain and pipeline fill
	localparam int max_cycles     = reset_cycles + directed_bound + random_count + 20;

	typedef struct packed {
		logic [31:0] due;
		logic        wr;
		logic [4:0]  rd;
		logic [2:0]  ppp;
		logic [63:0] data;
	} expect_t;

	logic        clk = 1'b0;
	logic        reset;
	logic [0:31] instruction;
	wb_rec_t     wb;
	logic [63:0] model_regs [reg_count];
	expect_t     exp_q [$];
	expect_t     head;
	int          cycles = 0;
	integer      seed;

	vector_core vector_core_i (
		.clk         (clk),
		.reset       (reset),
		.instruction (instruction),
		.wb          (wb)
	);

	always #20 clk = ~clk;

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
		else
			stop_with_failure($sformatf("ERROR at %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
	endtask

	function automatic logic [63:0] merge_ref(input logic [63:0] new_word,
		input logic [63:0] old_word, input logic [2:0] ppp);
		logic [63:0] merged;
		logic take;
		merged = old_word;
		for (int i = 0; i < 8; i++)
		begin
			case (ppp) // byte 0 is the most significant
				3'd0:    take = 1'b1;
				3'd1:    take = i < 4;
				3'd2:    take = i >= 4;
				3'd3:    take = (i % 2) == 0;
				3'd4:    take = (i % 2) == 1;
				default: take = 1'b0;
			endcase
			if (take)
				merged[63-8*i -: 8] = new_word[63-8*i -: 8];
		end
		return merged;
	endfunction

	function automatic logic [63:0] alu_ref(input int code, input int ww, input logic [63:0] a,
		input logic [63:0] b, input logic [4:0] imm);
		int lw;
		logic [63:0] mask;
		logic [63:0] x;
		logic [63:0] y;
		logic [63:0] r;
		logic signed [63:0] xs;
		logic [63:0] res;
		case (code)
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			op_not:  return ~a;
			op_mov:  return a;
			default: ;
		endcase
		lw = 8 << ww;
		mask = (lw == 64) ? '1 : (64'd1 << lw) - 1;
		res = '0;
		for (int j = 0; j < 64 / lw; j++)
		begin
			x = (a >> (j * lw)) & mask;
			y = (b >> (j * lw)) & mask;
			xs = $signed(x << (64 - lw)) >>> (64 - lw); // lane sign extended
			case (code)
				op_add:  r = x + y;
				op_sub:  r = x - y;
				op_rtth: r = (x << (lw / 2)) | (x >> (lw / 2));
				op_sll:  r = x << (y & (lw - 1));
				op_slli: r = x << (imm & (lw - 1));
				op_srl:  r = x >> (y & (lw - 1));
				op_srli: r = x >> (imm & (lw - 1));
				op_sra:  r = xs >>> (y & (lw - 1));
				op_srai: r = xs >>> (imm & (lw - 1));
				default: r = '0; // nop, multiplies, codes past srai
			endcase
			res |= (r & mask) << (j * lw);
		end
		return res;
	endfunction

	function automatic logic [0:31] alu_word(input int op, input int ww, input int ppp,
		input int rd, input int ra, input int rb);
		logic [5:0] fn;
		fn = 6'(op - 1);
		return {opcode_alu, 5'(rd), 5'(ra), 5'(rb), 3'(ppp), 2'(ww), fn};
	endfunction

	// drive one word, run the model on it and queue the expected wb record
	task automatic issue(input logic [0:31] word);
		expect_t e;
		logic [4:0] rd;
		@(posedge clk);
		instruction <= word;
		rd = word[rd_pos +: 5];
		e = '0;
		e.due = cycles + 4; // negedge after wb loads
		if (word[opcode_pos +: opcode_width] == opcode_alu)
		begin
			e.wr = rd != '0;
			e.rd = rd;
			e.ppp = word[ppp_pos +: 3];
			e.data = alu_ref(int'(word[fn_pos +: fn_width]) + 1, int'(word[ww_pos +: 2]),
				model_regs[word[ra_pos +: 5]], model_regs[word[rb_pos +: 5]],
				word[rb_pos +: 5]);
			if (e.wr)
				model_regs[rd] = merge_ref(e.data, model_regs[rd], e.ppp);
		end
		exp_q.push_back(e);
	endtask

	always @(negedge clk)
	begin
		if (exp_q.size() > 0 && exp_q[0].due == cycles)
		begin
			head = exp_q.pop_front();
			check_value("wb.wr", wb.wr, head.wr);
			if (head.wr)
			begin
				check_value("wb.rd", wb.rd, head.rd);
				check_value("wb.ppp", wb.ppp, head.ppp);
				check_value("wb.data", wb.data, head.data);
			end
		end
		else
			check_value("wb.wr", wb.wr, 1'b0); // reset or nothing in flight
		assert (vector_core_i.props_i.failures == 0)
		else
			stop_with_failure("a bound write-back assertion failed");
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > max_cycles)
			stop_with_failure("timeout: the run went past its cycle limit");
	end

	initial
	begin
		int w;
		int k;
		logic [31:0] r;
		logic [31:0] sel;
		logic [0:31] word;
		seed = 32'hd232ded0;
		reset = 1'b1;
		instruction = '0;
		for (int i = 0; i < reg_count; i++)
			model_regs[i] = '0;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;

		// idle and non-alu words write nothing
		issue('0);
		issue({6'b000001, 26'h3ffffff});
		issue({6'b101011, 26'h1234567});
		issue({6'b111111, 26'h0abcdef});

		// logic ops on full words built up from r0
		issue(alu_word(op_not, 3, ppp_all, 1, 0, 0));  // all ones
		issue(alu_word(op_srli, 3, ppp_all, 2, 1, 7));
		issue(alu_word(op_rtth, 1, ppp_all, 3, 2, 0));
		issue(alu_word(op_add, 0, ppp_all, 4, 3, 1));
		issue(alu_word(op_xor, 3, ppp_all, 5, 4, 2));
		issue(alu_word(op_and, 3, ppp_all, 6, 5, 3));
		issue(alu_word(op_or, 3, ppp_all, 7, 6, 2));
		issue(alu_word(op_mov, 3, ppp_all, 8, 7, 0));

		// add and sub with carries and borrows at every lane boundary
		for (w = 0; w < 4; w++)
		begin
			issue(alu_word(op_add, w, ppp_all, 9, 4, 4));
			issue(alu_word(op_sub, w, ppp_all, 10, 4, 1));
		end

		// odd shift codes read b lanes and even codes the immediate
		for (w = 0; w < 4; w++)
		begin
			issue(alu_word(op_rtth, w, ppp_all, 11, 4, 0));
			for (k = op_sll; k <= op_srai; k++)
				issue(alu_word(k, w, ppp_all, 12 + k - op_sll, 4, (k % 2 == 0) ? 9 * w + 3 : 9));
		end

		// dependent chain at distance 1, 2 and 3 with partial writes
		issue(alu_word(op_add, 1, ppp_upper, 12, 4, 5));
		issue(alu_word(op_xor, 3, ppp_odd, 13, 12, 3));
		issue(alu_word(op_sub, 0, ppp_even, 14, 6, 12));
		issue(alu_word(op_or, 3, ppp_lower, 12, 12, 13));
		issue(alu_word(op_not, 3, ppp_all, 0, 0, 0));   // rd 0 writes nothing
		issue(alu_word(op_add, 2, ppp_all, 15, 0, 12));
		issue(alu_word(op_mov, 3, 6, 15, 14, 0));        // ppp 6 selects no bytes
		issue(alu_word(op_add, 3, ppp_all, 16, 15, 15));

		// seeded random words with some non-alu opcodes
		for (k = 0; k < random_count; k++)
		begin
			r = $random(seed);
			sel = $random(seed);
			word = r;
			if (sel[1:0] != 2'b00)
				word[opcode_pos +: opcode_width] = opcode_alu;
			if (sel[2])
				word[fn_pos +: fn_width] = 6'($unsigned($random(seed)) % 16);
			issue(word);
		end

		repeat (4) issue('0);
		while (exp_q.size() > 0)
			@(negedge clk);
		if (vector_core_i.props_i.failures == 0)
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
		else
			stop_with_failure("bound write-back assertions failed during the run");
	end

endmodule

`default_nettype wire

// ==== src.f ====
source/vector_pkg.sv
source/vector_regfile.sv
source/vector_alu.sv
source/vector_decode.sv
source/vector_execute.sv
source/vector_core.sv
test/vector_core_properties.sv
test/vector_core_tb.sv
